// ==== verif/program.hex ====
// one 32-bit instruction word per line, from byte address 0 upward
// sum 1..10 in x1, round trip through word 0x100, report via 0x2000/0x2004
00000093 // 0x00 addi x1, x0, 0
00100113 // 0x04 addi x2, x0, 1
00B00193 // 0x08 addi x3, x0, 11
002080B3 // 0x0c add  x1, x1, x2
00110113 // 0x10 addi x2, x2, 1
FE311CE3 // 0x14 bne  x2, x3, 0x0c
10102023 // 0x18 sw   x1, 256(x0)
10002203 // 0x1c lw   x4, 256(x0)
401202B3 // 0x20 sub  x5, x4, x1
000023B7 // 0x24 lui  x7, 0x2
00029463 // 0x28 bne  x5, x0, 0x30
0100006F // 0x2c jal  x0, 0x3c
00200313 // 0x30 addi x6, x0, 2
0063A023 // 0x34 sw   x6, 0(x7)
0000006F // 0x38 jal  x0, 0x38
0013A223 // 0x3c sw   x1, 4(x7)
00100313 // 0x40 addi x6, x0, 1
0063A023 // 0x44 sw   x6, 0(x7)
0000006F // 0x48 jal  x0, 0x48

// ==== all.f ====
hw/rv_isa_pkg.sv
hw/mem_map_pkg.sv
hw/core_decode.sv
hw/core_execute.sv
hw/core_result.sv
hw/tiny_core.sv
hw/mm_ram.sv
hw/core_wrapper.sv
verif/core_wrapper_sva.sv
verif/tb_core_wrapper.sv

// ==== Bender.yml ====
package:
  name: core_wrapper

sources:
  - hw/rv_isa_pkg.sv
  - hw/mem_map_pkg.sv
  - hw/core_decode.sv
  - hw/core_execute.sv
  - hw/core_result.sv
  - hw/tiny_core.sv
  - hw/mm_ram.sv
  - hw/core_wrapper.sv
  - target: simulation
    files:
      - verif/core_wrapper_sva.sv
      - verif/tb_core_wrapper.sv

// ==== verif/tb_core_wrapper.sv ====
// core wrapper testbench
`timescale 1ns/10ps

module tb_core_wrapper;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SETTLE_CYCLES  = 50;
    localparam int LOOP_LIMIT     = 10;

    logic        clk;
    logic        rst_n;
    logic        fetch_enable;
    logic        tests_passed;
    logic        tests_failed;
    logic        exit_valid;
    logic [31:0] exit_value;

    integer      seed;
    int          hold_cycles;
    int          cycles;
    logic [31:0] expected_sum;

    core_wrapper core_wrapper_inst (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .fetch_enable_i ( fetch_enable ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_valid_o   ( exit_valid   ),
        .exit_value_o   ( exit_value   )
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // reference sum of 1 to n, the value the program loop accumulates
    function automatic logic [31:0] sum_up_to(input int n);
        logic [31:0] acc;
        acc = '0;
        for (int k = 1; k <= n; k++) begin
            acc = acc + k;
        end
        return acc;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    // nothing may be fetched or reported before the core is enabled
    task automatic expect_idle();
        assert (!exit_valid && !tests_passed && !tests_failed) else begin
            abort_run($sformatf("error at time %0t: status outputs %b%b%b set too early",
                                $time, exit_valid, tests_passed, tests_failed));
        end
        assert (!core_wrapper_inst.instr_req.req) else begin
            abort_run($sformatf("error at time %0t: fetch while fetch_enable_i is low", $time));
        end
    endtask

    task automatic expect_final(input logic [31:0] sum);
        assert (exit_valid && tests_passed && !tests_failed) else begin
            abort_run($sformatf("error at time %0t: status outputs %b%b%b changed after pass",
                                $time, exit_valid, tests_passed, tests_failed));
        end
        assert (exit_value == sum) else begin
            abort_run($sformatf("error at time %0t: exit_value_o is %0d, expected %0d",
                                $time, exit_value, sum));
        end
    endtask

    // stop at the first failed protocol or status assertion
    always @(core_wrapper_inst.ram_i.sva_inst.err_count) begin
        if (core_wrapper_inst.ram_i.sva_inst.err_count != 0) begin
            abort_run($sformatf("a bound assertion failed at time %0t", $time));
        end
    end

    initial begin
        seed         = 32'h5e4;
        rst_n        = 1'b0;
        fetch_enable = 1'b0;
        expected_sum = sum_up_to(LOOP_LIMIT);
        hold_cycles  = 5 + ($unsigned($random(seed)) % 16);

        repeat (2) begin
            @(negedge clk);
            expect_idle();
        end
        rst_n = 1'b1;

        repeat (hold_cycles) begin
            @(negedge clk);
            expect_idle();
        end
        fetch_enable = 1'b1;

        // the exit store comes first in program order, status may only coincide
        cycles = 0;
        while (!exit_valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            assert (exit_valid || (!tests_passed && !tests_failed)) else begin
                abort_run($sformatf("error at time %0t: status set before exit_valid_o", $time));
            end
        end
        if (!exit_valid) begin
            abort_run($sformatf("timeout: exit_valid_o did not rise within %0d cycles",
                                TIMEOUT_CYCLES));
        end
        assert (exit_value == expected_sum) else begin
            abort_run($sformatf("error at time %0t: exit_value_o is %0d, expected %0d",
                                $time, exit_value, expected_sum));
        end

        // the same cycle budget covers the status store
        while (!tests_passed && !tests_failed && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!tests_passed && !tests_failed) begin
            abort_run($sformatf("timeout: no test status within %0d cycles", TIMEOUT_CYCLES));
        end
        assert (tests_passed && !tests_failed) else begin
            abort_run($sformatf("error at time %0t: program reported failure", $time));
        end

        repeat (SETTLE_CYCLES) begin
            @(negedge clk);
            expect_final(expected_sum);
        end

        if (core_wrapper_inst.ram_i.sva_inst.err_count != 0) begin
            abort_run($sformatf("%0d bound assertion failures were reported",
                                core_wrapper_inst.ram_i.sva_inst.err_count));
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== verif/core_wrapper_sva.sv ====
// memory protocol and status checks
`timescale 1ns/10ps

module core_wrapper_sva (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input mem_map_pkg::instr_req_t instr_req_i,
    input mem_map_pkg::data_req_t  data_req_i,
    input mem_map_pkg::mem_rsp_t   instr_rsp_i,
    input mem_map_pkg::mem_rsp_t   data_rsp_i,
    input logic                    tests_passed_i,
    input logic                    tests_failed_i,
    input logic                    exit_valid_i
);

    // number of failed assertions so far
    int unsigned err_count;

    initial begin
        err_count = 0;
    end

    instr_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rsp_i.gnt |-> instr_req_i.req)
        else begin $error("instruction grant without request"); err_count++; end

    data_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rsp_i.gnt |-> data_req_i.req)
        else begin $error("data grant without request"); err_count++; end

    // rvalid follows every grant by exactly one cycle, and never comes alone
    instr_gnt_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rsp_i.gnt |=> instr_rsp_i.rvalid)
        else begin $error("instruction rvalid missing after grant"); err_count++; end

    instr_rvalid_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rsp_i.rvalid |-> $past(instr_rsp_i.gnt))
        else begin $error("instruction rvalid without earlier grant"); err_count++; end

    data_gnt_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rsp_i.gnt |=> data_rsp_i.rvalid)
        else begin $error("data rvalid missing after grant"); err_count++; end

    data_rvalid_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rsp_i.rvalid |-> $past(data_rsp_i.gnt))
        else begin $error("data rvalid without earlier grant"); err_count++; end

    status_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(tests_passed_i && tests_failed_i))
        else begin $error("passed and failed both set"); err_count++; end

    status_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$fell(tests_passed_i) && !$fell(tests_failed_i) && !$fell(exit_valid_i))
        else begin $error("a status output fell after being set"); err_count++; end

endmodule

bind mm_ram core_wrapper_sva sva_inst (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .instr_req_i    ( instr_req_i    ),
    .data_req_i     ( data_req_i     ),
    .instr_rsp_i    ( instr_rsp_o    ),
    .data_rsp_i     ( data_rsp_o     ),
    .tests_passed_i ( tests_passed_o ),
    .tests_failed_i ( tests_failed_o ),
    .exit_valid_i   ( exit_valid_o   )
);

// ==== hw/core_wrapper.sv ====
// core and memory top level
`timescale 1ns/10ps

module core_wrapper (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        fetch_enable_i,
    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic        exit_valid_o,
    output logic [31:0] exit_value_o
);

    mem_map_pkg::instr_req_t instr_req;
    mem_map_pkg::mem_rsp_t   instr_rsp;
    mem_map_pkg::data_req_t  data_req;
    mem_map_pkg::mem_rsp_t   data_rsp;

    tiny_core core_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .instr_req_o    ( instr_req      ),
        .instr_rsp_i    ( instr_rsp      ),
        .data_req_o     ( data_req       ),
        .data_rsp_i     ( data_rsp       )
    );

    mm_ram ram_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .instr_req_i    ( instr_req      ),
        .data_req_i     ( data_req       ),
        .instr_rsp_o    ( instr_rsp      ),
        .data_rsp_o     ( data_rsp       ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   )
    );

endmodule

// ==== hw/mm_ram.sv ====
// memory with status peripherals
`timescale 1ns/10ps

module mm_ram (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mem_map_pkg::instr_req_t instr_req_i,
    input  mem_map_pkg::data_req_t  data_req_i,
    output mem_map_pkg::mem_rsp_t   instr_rsp_o,
    output mem_map_pkg::mem_rsp_t   data_rsp_o,
    output logic                    tests_passed_o,
    output logic                    tests_failed_o,
    output logic                    exit_valid_o,
    output logic [31:0]             exit_value_o
);
    import mem_map_pkg::*;

    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] instr_idx;
    logic [RAM_AW-1:0] data_idx;
    logic              status_wr;
    logic              exit_wr;
    logic              ram_wr;
    logic              instr_rvalid_q;
    logic              data_rvalid_q;
    logic [31:0]       instr_rdata_q;
    logic [31:0]       data_rdata_q;

    initial begin
        $readmemh("verif/program.hex", mem);
    end

    assign instr_idx = instr_req_i.addr[RAM_AW+1:2];
    assign data_idx  = data_req_i.addr[RAM_AW+1:2];

    // the peripheral addresses would alias the array, so they never reach it
    assign status_wr = data_req_i.req && data_req_i.we && data_req_i.addr == STATUS_ADDR;
    assign exit_wr   = data_req_i.req && data_req_i.we && data_req_i.addr == EXIT_ADDR;
    assign ram_wr    = data_req_i.req && data_req_i.we && !status_wr && !exit_wr;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else begin
            instr_rvalid_q <= instr_req_i.req;
            data_rvalid_q  <= data_req_i.req;
            if (status_wr) begin
                tests_passed_o <= tests_passed_o | (data_req_i.wdata == PASS_CODE);
                tests_failed_o <= tests_failed_o | (data_req_i.wdata != PASS_CODE);
            end
            if (exit_wr) begin
                exit_valid_o <= 1'b1;
                exit_value_o <= data_req_i.wdata;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_req_i.req) begin
            instr_rdata_q <= mem[instr_idx];
        end
        if (data_req_i.req) begin
            data_rdata_q <= mem[data_idx];
        end
        if (ram_wr) begin
            mem[data_idx] <= data_req_i.wdata;
        end
    end

    // both ports are granted in the cycle their request is seen
    assign instr_rsp_o = '{gnt: instr_req_i.req, rvalid: instr_rvalid_q, rdata: instr_rdata_q};
    assign data_rsp_o  = '{gnt: data_req_i.req, rvalid: data_rvalid_q, rdata: data_rdata_q};

endmodule

// ==== hw/tiny_core.sv ====
// minimal rv32 core
`timescale 1ns/10ps

module tiny_core (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    fetch_enable_i,
    output mem_map_pkg::instr_req_t instr_req_o,
    input  mem_map_pkg::mem_rsp_t   instr_rsp_i,
    output mem_map_pkg::data_req_t  data_req_o,
    input  mem_map_pkg::mem_rsp_t   data_rsp_i
);
    import rv_isa_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [31:0]           rs1_data;
    logic [31:0]           rs2_data;
    logic                  issue;
    dec_op_t               op;
    logic                  done;
    redirect_t             redirect;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [31:0]           wb_data;

    core_decode decode_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .instr_req_o    ( instr_req_o    ),
        .instr_rsp_i    ( instr_rsp_i    ),
        .rs1_addr_o     ( rs1_addr       ),
        .rs2_addr_o     ( rs2_addr       ),
        .rs1_data_i     ( rs1_data       ),
        .rs2_data_i     ( rs2_data       ),
        .issue_o        ( issue          ),
        .op_o           ( op             ),
        .done_i         ( done           ),
        .redirect_i     ( redirect       )
    );

    core_execute execute_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .issue_i        ( issue          ),
        .op_i           ( op             ),
        .data_req_o     ( data_req_o     ),
        .data_rsp_i     ( data_rsp_i     ),
        .wb_en_o        ( wb_en          ),
        .wb_addr_o      ( wb_addr        ),
        .wb_data_o      ( wb_data        ),
        .done_o         ( done           ),
        .redirect_o     ( redirect       )
    );

    core_result result_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .rs1_addr_i     ( rs1_addr       ),
        .rs2_addr_i     ( rs2_addr       ),
        .wb_en_i        ( wb_en          ),
        .wb_addr_i      ( wb_addr        ),
        .wb_data_i      ( wb_data        ),
        .rs1_data_o     ( rs1_data       ),
        .rs2_data_o     ( rs2_data       )
    );

endmodule

// ==== hw/core_result.sv ====
// register file
`timescale 1ns/10ps

module core_result (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                              wb_en_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [31:0]                       wb_data_i,
    output logic [31:0]                       rs1_data_o,
    output logic [31:0]                       rs2_data_o
);
    import rv_isa_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // x0 has no storage, it always reads as zero
    logic [31:0] regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_en_i && wb_addr_i != '0) begin
            regs_q[wb_addr_i] <= wb_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// ==== hw/core_execute.sv ====
// execute stage with data port
`timescale 1ns/10ps

module core_execute (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              issue_i,
    input  rv_isa_pkg::dec_op_t               op_i,
    output mem_map_pkg::data_req_t            data_req_o,
    input  mem_map_pkg::mem_rsp_t             data_rsp_i,
    output logic                              wb_en_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [31:0]                       wb_data_o,
    output logic                              done_o,
    output rv_isa_pkg::redirect_t             redirect_o
);
    import rv_isa_pkg::*;

    logic [31:0]           operand_b;
    logic [31:0]           alu_res;
    logic                  mem_req_q;
    logic                  mem_wait_q;
    logic                  mem_load_q;
    logic                  done_q;
    logic                  wb_en_q;
    logic                  taken_q;
    logic [REG_ADDR_W-1:0] wb_addr_q;
    logic [31:0]           wb_data_q;
    logic [31:0]           target_q;
    logic [31:0]           addr_q;
    logic [31:0]           wdata_q;

    // loads and stores reuse the adder for rs1 + offset
    assign operand_b = op_i.use_imm ? op_i.imm : op_i.rs2_val;
    assign alu_res   = (op_i.alu_op == ALU_SUB) ? op_i.rs1_val - operand_b
                                                : op_i.rs1_val + operand_b;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_req_q  <= 1'b0;
            mem_wait_q <= 1'b0;
            mem_load_q <= 1'b0;
            done_q     <= 1'b0;
            wb_en_q    <= 1'b0;
            taken_q    <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            wb_en_q <= 1'b0;
            taken_q <= 1'b0;
            if (issue_i) begin
                case (op_i.kind)
                    OP_LOAD, OP_STORE: begin
                        mem_req_q  <= 1'b1;
                        mem_load_q <= op_i.kind == OP_LOAD;
                    end
                    OP_BRANCH: begin
                        done_q  <= 1'b1;
                        taken_q <= op_i.rs1_val != op_i.rs2_val;
                    end
                    OP_JUMP: begin
                        done_q  <= 1'b1;
                        wb_en_q <= 1'b1;
                        taken_q <= 1'b1;
                    end
                    default: begin
                        done_q  <= 1'b1;
                        wb_en_q <= 1'b1;
                    end
                endcase
            end
            if (mem_req_q && data_rsp_i.gnt) begin
                mem_req_q  <= 1'b0;
                mem_wait_q <= 1'b1;
            end
            // a store ends on its rvalid too, only loads write back
            if (mem_wait_q && data_rsp_i.rvalid) begin
                mem_wait_q <= 1'b0;
                done_q     <= 1'b1;
                wb_en_q    <= mem_load_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            wb_addr_q <= op_i.rd;
            target_q  <= op_i.pc + op_i.imm;
            addr_q    <= alu_res;
            wdata_q   <= op_i.rs2_val;
            case (op_i.kind)
                OP_LUI:  wb_data_q <= op_i.imm;
                OP_JUMP: wb_data_q <= op_i.pc + 32'd4;
                default: wb_data_q <= alu_res;
            endcase
        end else if (mem_wait_q && data_rsp_i.rvalid) begin
            wb_data_q <= data_rsp_i.rdata;
        end
    end

    assign data_req_o = '{req: mem_req_q, we: !mem_load_q, addr: addr_q, wdata: wdata_q};
    assign redirect_o = '{taken: taken_q, target: target_q};
    assign wb_en_o    = wb_en_q;
    assign wb_addr_o  = wb_addr_q;
    assign wb_data_o  = wb_data_q;
    assign done_o     = done_q;

endmodule

// ==== hw/core_decode.sv ====
// fetch and decode stage
`timescale 1ns/10ps

module core_decode (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              fetch_enable_i,
    output mem_map_pkg::instr_req_t           instr_req_o,
    input  mem_map_pkg::mem_rsp_t             instr_rsp_i,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [31:0]                       rs1_data_i,
    input  logic [31:0]                       rs2_data_i,
    output logic                              issue_o,
    output rv_isa_pkg::dec_op_t               op_o,
    input  logic                              done_i,
    input  rv_isa_pkg::redirect_t             redirect_i
);
    import rv_isa_pkg::*;
    import mem_map_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_WAIT_INSTR, S_ISSUE, S_WAIT_DONE} state_e;

    state_e      state_q;
    logic [31:0] pc_q;
    logic [31:0] instr_q;
    logic [6:0]  opcode;

    assign opcode      = instr_q[6:0];
    assign instr_req_o = '{req: state_q == S_FETCH, addr: pc_q};
    assign issue_o     = state_q == S_ISSUE;

    // operands are read in the issue cycle, so they see the last writeback
    assign rs1_addr_o = instr_q[19:15];
    assign rs2_addr_o = instr_q[24:20];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            pc_q    <= BOOT_ADDR;
        end else begin
            case (state_q)
                S_IDLE:       if (fetch_enable_i) state_q <= S_FETCH;
                S_FETCH:      if (instr_rsp_i.gnt) state_q <= S_WAIT_INSTR;
                S_WAIT_INSTR: if (instr_rsp_i.rvalid) state_q <= S_ISSUE;
                S_ISSUE:      state_q <= S_WAIT_DONE;
                S_WAIT_DONE: begin
                    if (done_i) begin
                        state_q <= fetch_enable_i ? S_FETCH : S_IDLE;
                        pc_q    <= redirect_i.taken ? redirect_i.target : pc_q + 32'd4;
                    end
                end
                default:      state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_WAIT_INSTR && instr_rsp_i.rvalid) begin
            instr_q <= instr_rsp_i.rdata;
        end
    end

    always_comb begin
        op_o         = '0;
        op_o.kind    = OP_ALU;
        op_o.alu_op  = ALU_ADD;
        op_o.use_imm = 1'b1;
        op_o.rd      = instr_q[11:7];
        op_o.rs1_val = rs1_data_i;
        op_o.rs2_val = rs2_data_i;
        op_o.pc      = pc_q;
        case (opcode)
            OPC_LUI: begin
                op_o.kind = OP_LUI;
                op_o.imm  = {instr_q[31:12], 12'b0};
            end
            OPC_OP_IMM: op_o.imm = {{20{instr_q[31]}}, instr_q[31:20]};
            OPC_OP: begin
                op_o.use_imm = 1'b0;
                op_o.alu_op  = (instr_q[31:25] == F7_SUB) ? ALU_SUB : ALU_ADD;
            end
            OPC_LOAD: begin
                op_o.kind = OP_LOAD;
                op_o.imm  = {{20{instr_q[31]}}, instr_q[31:20]};
            end
            OPC_STORE: begin
                op_o.kind = OP_STORE;
                op_o.rd   = '0;
                op_o.imm  = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
            end
            OPC_BRANCH: begin
                op_o.kind = OP_BRANCH;
                op_o.rd   = '0;
                op_o.imm  = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                             instr_q[30:25], instr_q[11:8], 1'b0};
            end
            OPC_JAL: begin
                op_o.kind = OP_JUMP;
                op_o.imm  = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                             instr_q[20], instr_q[30:21], 1'b0};
            end
            // anything else retires as a nop
            default: op_o.rd = '0;
        endcase
    end

endmodule

// ==== hw/mem_map_pkg.sv ====
// memory map and bus types
package mem_map_pkg;

    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    localparam logic [31:0] BOOT_ADDR = 32'h0000_0000;

    // pseudo peripherals, decoded ahead of the word array
    localparam logic [31:0] STATUS_ADDR = 32'h0000_2000;
    localparam logic [31:0] EXIT_ADDR   = 32'h0000_2004;
    localparam logic [31:0] PASS_CODE   = 32'd1;

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } instr_req_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } data_req_t;

    // shared by both ports, rvalid follows gnt by one cycle
    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

// ==== hw/rv_isa_pkg.sv ====
// rv32 subset definitions
package rv_isa_pkg;

    localparam int REG_ADDR_W = 5;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct7 that turns ADD into SUB
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_LUI,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JUMP
    } op_kind_e;

    typedef enum logic {
        ALU_ADD,
        ALU_SUB
    } alu_op_e;

    // use_imm selects the immediate instead of rs2 as second ALU operand
    typedef struct packed {
        op_kind_e              kind;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [31:0]           rs1_val;
        logic [31:0]           rs2_val;
        logic [31:0]           imm;
        logic [31:0]           pc;
    } dec_op_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

endpackage
